/* uartPkg.sv */
// ----------------------------------------------------------------------
// uart echo shared definitions
// byte, tick and slot widths, 8N1 frame constants and FSM states
// ----------------------------------------------------------------------

package uartPkg;

  // ---------------------------------------------------------------------
  // frame layout
  // ---------------------------------------------------------------------
  localparam int DataBits = 8;              // 8N1, no parity

  typedef logic [DataBits-1:0] uartByteT;   // one payload byte
  typedef logic [3:0]          subTickT;    // tick inside a bit, 0..15
  typedef logic [3:0]          bitSlotT;    // 0 start, 1..8 data, 9 stop

  // stop bit slot, right after the last data bit
  localparam bitSlotT StopSlot = 4'd9;

  // middle of the bit
  localparam subTickT SampleTick = 4'd8;

  // ---------------------------------------------------------------------
  // state machines
  // ---------------------------------------------------------------------
  typedef enum logic [1:0] {
    rxIdle,     // watching the filter for a falling edge
    rxFrame,    // start and data slots
    rxStop      // waiting for the stop bit sample
  } rxStateT;

  typedef enum logic {
    txIdle,     // line high, nothing queued
    txFrame     // start, data, stop
  } txStateT;

endpackage

/* uartBaudTick.sv */
// ----------------------------------------------------------------------
// baud tick divider, one clock wide enable every BaudDiv clocks
// ----------------------------------------------------------------------

module uartBaudTick #(
  parameter int BaudDiv = 16
) (
  input  logic clk_29_pll,
  input  logic reset,
  output logic baudTick
);

  localparam int CntW = (BaudDiv > 1) ? $clog2(BaudDiv) : 1;

  logic [CntW-1:0] divCnt;   // clocks since last tick
  logic            wrapNow;

  assign wrapNow = (divCnt == CntW'(BaudDiv - 1));

  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      divCnt   <= '0;
      baudTick <= 1'b0;
    end else begin
      baudTick <= wrapNow;               // registered, first tick BaudDiv clocks in
      if (wrapNow) begin
        divCnt <= '0;
      end else begin
        divCnt <= divCnt + 1'b1;
      end
    end
  end

  // tick is an enable, never a level
  assert property (@(posedge clk_29_pll) disable iff (!reset) baudTick |=> !baudTick)
    else $error("baudTick high for two clocks");

endmodule

/* uartReceiver.sv */
// ----------------------------------------------------------------------
// uart receiver, 8N1 with input filter, mid-bit sampling and stop check
// ----------------------------------------------------------------------

module uartReceiver (
  input  logic              clk_29_pll,
  input  logic              reset,
  input  logic              baudTick,
  input  logic              rxd,
  output logic              rxValid,
  output uartPkg::uartByteT rxByte,
  output logic              rxFrameError
);

  import uartPkg::*;

  rxStateT    rxState;
  logic [3:0] rxFilt;        // [0] newest sample, [3] oldest
  subTickT    subTick;
  bitSlotT    slot;
  uartByteT   rxShift;       // data bits, lsb arrives first

  logic startSeen;
  logic bitIn;
  logic sampleNow;
  logic falseStart;
  logic dataSample;
  logic stopSample;

  // ---------------------------------------------------------------------
  // start detection and sample strobes
  // ---------------------------------------------------------------------
  // two high then two low, a one-tick dip never matches
  assign startSeen  = rxFilt[3] & rxFilt[2] & ~rxFilt[1] & ~rxFilt[0];
  assign bitIn      = rxFilt[1];   // closest stage to bit centre
  assign sampleNow  = baudTick && (subTick == SampleTick);

  // start bit gone high again by mid-bit, treat as noise
  assign falseStart = sampleNow && (rxState == rxFrame) && (slot == '0) && bitIn;
  assign dataSample = sampleNow && (rxState == rxFrame) && (slot != '0);
  assign stopSample = sampleNow && (rxState == rxStop);

  // ---------------------------------------------------------------------
  // frame FSM
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      rxState      <= rxIdle;
      rxFilt       <= '0;          // low, so no start until line seen high
      subTick      <= '0;
      slot         <= '0;
      rxValid      <= 1'b0;
      rxFrameError <= 1'b0;
    end else begin
      rxValid      <= stopSample && bitIn;    // good stop
      rxFrameError <= stopSample && !bitIn;   // stop sampled low

      if (baudTick) begin
        rxFilt <= {rxFilt[2:0], rxd};
      end

      case (rxState)
        rxIdle: begin
          if (baudTick && startSeen) begin
            rxState <= rxFrame;
            subTick <= '0;
            slot    <= '0;
          end
        end
        rxFrame: begin
          if (falseStart) begin
            rxState <= rxIdle;
          end else if (baudTick) begin
            subTick <= subTick + 1'b1;
            if (subTick == '1) begin
              slot <= slot + 1'b1;
              if (slot == bitSlotT'(DataBits)) begin
                rxState <= rxStop;         // last data bit done
              end
            end
          end
        end
        rxStop: begin
          if (stopSample) begin
            rxState <= rxIdle;             // back to watching, half a bit early
          end else if (baudTick) begin
            subTick <= subTick + 1'b1;
          end
        end
        default: rxState <= rxIdle;
      endcase
    end
  end

  // payload path
  always_ff @(posedge clk_29_pll) begin
    if (dataSample) begin
      rxShift <= {bitIn, rxShift[DataBits-1:1]};   // shift in from the top
    end
    if (stopSample && bitIn) begin
      rxByte <= rxShift;                            // held until next good byte
    end
  end

  assert property (@(posedge clk_29_pll) disable iff (!reset) !(rxValid && rxFrameError))
    else $error("rxValid and rxFrameError together");

endmodule

/* echoFifo.sv */
// ----------------------------------------------------------------------
// echo byte FIFO between receiver and transmitter, drops when full
// ----------------------------------------------------------------------

module echoFifo #(
  parameter int FifoDepth = 4
) (
  input  logic              clk_29_pll,
  input  logic              reset,
  input  logic              push,
  input  logic              pop,
  input  uartPkg::uartByteT pushByte,
  output logic              notEmpty,
  output uartPkg::uartByteT headByte
);

  import uartPkg::*;

  localparam int AddrW = $clog2(FifoDepth);   // depth is a power of two

  uartByteT         mem [FifoDepth];
  logic [AddrW-1:0] wrPtr;
  logic [AddrW-1:0] rdPtr;
  logic [AddrW:0]   fillCnt;   // one extra bit for the full case

  logic full;
  logic pushOk;
  logic popOk;

  assign full     = (fillCnt == (AddrW + 1)'(FifoDepth));
  assign notEmpty = (fillCnt != '0);
  assign pushOk   = push && !full;       // receiver never stalls
  assign popOk    = pop && notEmpty;
  assign headByte = mem[rdPtr];          // oldest entry, shown directly

  // ---------------------------------------------------------------------
  // pointers and occupancy
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      wrPtr   <= '0;
      rdPtr   <= '0;
      fillCnt <= '0;
    end else begin
      if (pushOk) begin
        wrPtr <= wrPtr + 1'b1;           // wraps on its own
      end
      if (popOk) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({pushOk, popOk})
        2'b10:   fillCnt <= fillCnt + 1'b1;
        2'b01:   fillCnt <= fillCnt - 1'b1;
        default: fillCnt <= fillCnt;     // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_29_pll) begin
    if (pushOk) begin
      mem[wrPtr] <= pushByte;
    end
  end

  // transmitter only pops what it saw waiting
  assert property (@(posedge clk_29_pll) disable iff (!reset) pop |-> notEmpty)
    else $error("pop on empty FIFO");

endmodule

/* uartTransmitter.sv */
// ----------------------------------------------------------------------
// uart transmitter that pops a byte and sends it as an 8N1 frame on txd
// ----------------------------------------------------------------------

module uartTransmitter (
  input  logic              clk_29_pll,
  input  logic              reset,
  input  logic              baudTick,
  input  logic              notEmpty,
  input  uartPkg::uartByteT headByte,
  output logic              pop,
  output logic              txd,
  output logic              txBusy
);

  import uartPkg::*;

  localparam int IdxW = $clog2(DataBits);

  txStateT         txState;
  uartByteT        txByte;    // copy of the popped byte
  subTickT         subTick;
  bitSlotT         slot;
  logic [IdxW-1:0] bitIdx;
  logic            txLevel;
  logic            lastTick;
  logic            frameDone;

  // last tick of the stop bit where a waiting byte follows without a gap
  assign lastTick  = baudTick && (txState == txFrame) && (slot == StopSlot) && (subTick == '1);
  assign frameDone = baudTick && (txState == txFrame) && (slot > StopSlot);
  // a byte that lands late in the stop bit still keeps txBusy high
  assign pop       = notEmpty && ((txState == txIdle) || lastTick || frameDone);
  assign txBusy    = (txState == txFrame);
  assign bitIdx    = IdxW'(slot - 1'b1);   // slot 1 carries bit 0

  // start, data lsb first, then stop and idle level
  always_comb begin
    if (slot == '0) begin
      txLevel = 1'b0;
    end else if (slot <= bitSlotT'(DataBits)) begin
      txLevel = txByte[bitIdx];
    end else begin
      txLevel = 1'b1;
    end
  end

  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      txState <= txIdle;
      subTick <= '0;
      slot    <= '0;
      txd     <= 1'b1;                    // line idles high
    end else begin
      case (txState)
        txIdle: begin
          if (pop) begin
            txState <= txFrame;           // start bit on the next tick
            subTick <= '0;
            slot    <= '0;
          end
        end
        txFrame: begin
          if (frameDone && !pop) begin
            txState <= txIdle;            // stop bit sent and nothing waiting
          end else if (baudTick) begin
            txd <= txLevel;
            if (pop) begin
              subTick <= '0;              // back to back restart at the start bit
              slot    <= '0;
            end else begin
              subTick <= subTick + 1'b1;
              if (subTick == '1) begin
                slot <= slot + 1'b1;
              end
            end
          end
        end
        default: txState <= txIdle;
      endcase
    end
  end

  // byte latch
  always_ff @(posedge clk_29_pll) begin
    if (pop) begin
      txByte <= headByte;
    end
  end

  assert property (@(posedge clk_29_pll) disable iff (!reset) !txBusy |-> txd)
    else $error("txd low while transmitter idle");

endmodule

/* uartEcho.sv */
// ----------------------------------------------------------------------
// uart echo top, receiver into a byte FIFO, FIFO back out on txd
// ----------------------------------------------------------------------

module uartEcho #(
  parameter int BaudDiv   = 16,   // 29.49 MHz / 16 = 1.8432 MHz ticks
  parameter int FifoDepth = 4
) (
  input  logic              clk_29_pll,
  input  logic              reset,
  input  logic              rxd,
  output logic              txd,
  output logic              txBusy,
  output logic              rxValid,
  output uartPkg::uartByteT rxByte,
  output logic              rxFrameError
);

  import uartPkg::*;

  logic     baudTick;   // shared by both directions
  logic     notEmpty;
  logic     pop;
  uartByteT headByte;

  // ---------------------------------------------------------------------
  // baud timing
  // ---------------------------------------------------------------------
  uartBaudTick #(
    .BaudDiv (BaudDiv)
  ) i_baudTick (
    .clk_29_pll (clk_29_pll),
    .reset      (reset),
    .baudTick   (baudTick)
  );

  // ---------------------------------------------------------------------
  // receive, buffer, transmit
  // ---------------------------------------------------------------------
  uartReceiver i_receiver (
    .clk_29_pll   (clk_29_pll),
    .reset        (reset),
    .baudTick     (baudTick),
    .rxd          (rxd),
    .rxValid      (rxValid),
    .rxByte       (rxByte),
    .rxFrameError (rxFrameError)
  );

  echoFifo #(
    .FifoDepth (FifoDepth)
  ) i_fifo (
    .clk_29_pll (clk_29_pll),
    .reset      (reset),
    .push       (rxValid),      // good bytes only
    .pop        (pop),
    .pushByte   (rxByte),
    .notEmpty   (notEmpty),
    .headByte   (headByte)
  );

  uartTransmitter i_transmitter (
    .clk_29_pll (clk_29_pll),
    .reset      (reset),
    .baudTick   (baudTick),
    .notEmpty   (notEmpty),
    .headByte   (headByte),
    .pop        (pop),
    .txd        (txd),
    .txBusy     (txBusy)
  );

endmodule

/* tbUartEcho.sv */
// ----------------------------------------------------------------------
// uart echo testbench
// drives frames from echoInput.txt and checks the echo and the status outputs
// ----------------------------------------------------------------------

module tbUartEcho;

  import uartPkg::*;

  localparam int BitClocks       = 256;              // 16 ticks of 16 clocks
  localparam int GlitchClocks    = 20;               // under two ticks
  localparam int IdleCheckClocks = 600;
  localparam int EchoTimeout     = 6 * 10 * BitClocks;
  localparam int DrainTimeout    = 8 * 10 * BitClocks;
  localparam int WatchdogClocks  = 200000;
  localparam int StimDepth       = 32;

  logic     clk_29_pll;
  logic     reset;
  logic     rxd;
  logic     txd;
  logic     txBusy;
  logic     rxValid;
  uartByteT rxByte;
  logic     rxFrameError;

  logic [19:0] stim [StimDepth];   // kind, byte, stop flag, gap
  uartByteT    rxQ[$];             // good frames still owed an rxValid
  uartByteT    txQ[$];             // good frames still owed an echo
  logic        gaplessQ[$];        // echo follows the previous one with txBusy held
  uartByteT    rxExp;
  int          frameErrExp  = 0;
  int          frameErrSeen = 0;
  int          mismatchErrs = 0;
  int          otherErrs    = 0;

  uartEcho i_dut (
    .clk_29_pll   (clk_29_pll),
    .reset        (reset),
    .rxd          (rxd),
    .txd          (txd),
    .txBusy       (txBusy),
    .rxValid      (rxValid),
    .rxByte       (rxByte),
    .rxFrameError (rxFrameError)
  );

  initial begin
    clk_29_pll = 1'b0;
    forever #5 clk_29_pll = ~clk_29_pll;
  end

  // ---------------------------------------------------------------------
  // line driver holding one rxd level for a number of clocks
  // ---------------------------------------------------------------------
  task automatic driveLevel(input logic level, input int clocks);
    @(posedge clk_29_pll);
    rxd <= level;
    repeat (clocks - 1) @(posedge clk_29_pll);
  endtask

  // start, 8 data bits lsb first, stop
  task automatic sendFrame(input uartByteT data, input logic stopLevel);
    driveLevel(1'b0, BitClocks);
    for (int i = 0; i < DataBits; i++) begin
      driveLevel(data[i], BitClocks);
    end
    driveLevel(stopLevel, BitClocks);
  endtask

  // outputs quiet while nothing is sent
  task automatic checkIdle(input int clocks);
    repeat (clocks) begin
      @(negedge clk_29_pll);
      assert (txd === 1'b1 && txBusy === 1'b0 && rxValid === 1'b0 && rxFrameError === 1'b0)
        else begin
          mismatchErrs++;
          $display("Mismatch idle txd %h txBusy %h rxValid %h rxFrameError %h, expected 1 0 0 0",
                   txd, txBusy, rxValid, rxFrameError);
        end
    end
  endtask

  // transmitter busy while its frame is on the line
  task automatic checkTxBusy();
    assert (txBusy === 1'b1)
      else begin
        mismatchErrs++;
        $display("Mismatch txBusy: got %h expected 1", txBusy);
      end
  endtask

  // mid-bit sample of a fixed start or stop level
  task automatic checkTxBit(input logic expLevel);
    assert (txd === expLevel)
      else begin
        mismatchErrs++;
        $display("Mismatch txd framing bit: got %h expected %h", txd, expLevel);
      end
    checkTxBusy();
  endtask

  // ---------------------------------------------------------------------
  // monitors
  // ---------------------------------------------------------------------
  always @(negedge clk_29_pll) begin
    if (reset && rxValid) begin
      assert (rxQ.size() != 0)
        else begin
          otherErrs++;
          $display("rxValid pulsed with no good frame outstanding, rxByte %h", rxByte);
        end
      if (rxQ.size() != 0) begin
        rxExp = rxQ.pop_front();
        assert (rxByte === rxExp)
          else begin
            mismatchErrs++;
            $display("Mismatch rxByte: got %h expected %h", rxByte, rxExp);
          end
      end
    end
    if (reset && rxFrameError) begin
      frameErrSeen++;
    end
  end

  // rebuilds each echoed frame from txd
  task automatic watchEcho();
    int       waitCnt;
    uartByteT got;
    uartByteT expByte;
    forever begin
      waitCnt = 0;
      while (txd && waitCnt < EchoTimeout) begin
        @(negedge clk_29_pll);
        if (txQ.size() != 0) begin
          waitCnt++;                     // only counts while an echo is owed
          if (gaplessQ[0]) begin
            checkTxBusy();               // back to back echo keeps txBusy up
          end
        end
      end
      if (txd) begin
        otherErrs++;
        $display("no echo frame on txd within %0d clocks of a pending byte", EchoTimeout);
        expByte = txQ.pop_front();
        gaplessQ.delete(0);
      end else begin
        repeat (BitClocks / 2 - 1) @(negedge clk_29_pll);   // middle of start bit
        checkTxBit(1'b0);
        for (int i = 0; i < DataBits; i++) begin
          repeat (BitClocks) @(negedge clk_29_pll);
          got[i] = txd;
          checkTxBusy();
        end
        repeat (BitClocks) @(negedge clk_29_pll);
        checkTxBit(1'b1);                // stop bit
        assert (txQ.size() != 0)
          else begin
            otherErrs++;
            $display("echo frame %h on txd with no byte expected", got);
          end
        if (txQ.size() != 0) begin
          expByte = txQ.pop_front();
          gaplessQ.delete(0);
          assert (got === expByte)
            else begin
              mismatchErrs++;
              $display("Mismatch txd byte: got %h expected %h", got, expByte);
            end
        end
      end
    end
  endtask

  // ---------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------
  initial begin
    logic [19:0] entry;
    int          drainCnt;
    logic        prevGapless;
    reset       = 1'b0;
    rxd         = 1'b1;                  // line idles high
    prevGapless = 1'b0;
    $readmemh("echoInput.txt", stim);
    assert (!$isunknown(stim[0]))
      else begin
        otherErrs++;
        $display("stimulus file echoInput.txt could not be read");
      end
    repeat (10) @(posedge clk_29_pll);
    reset <= 1'b1;
    checkIdle(IdleCheckClocks);
    fork
      watchEcho();
    join_none
    for (int idx = 0; idx < StimDepth; idx++) begin
      entry = stim[idx];
      if ($isunknown(entry) || entry[19:16] == 4'hf) begin
        break;
      end
      if (entry[19:16] == 4'h1) begin
        driveLevel(1'b0, GlitchClocks);  // short dip the filter must ignore
        prevGapless = 1'b0;
      end else begin
        if (entry[4]) begin
          rxQ.push_back(entry[15:8]);
          txQ.push_back(entry[15:8]);
          gaplessQ.push_back(prevGapless);
        end else begin
          frameErrExp++;
        end
        sendFrame(entry[15:8], entry[4]);
        prevGapless = entry[4] && (entry[3:0] == 4'h0);
      end
      if (entry[3:0] != 4'h0) begin
        driveLevel(1'b1, entry[3:0] * BitClocks);
      end
    end
    driveLevel(1'b1, BitClocks);
    drainCnt = 0;
    while ((rxQ.size() != 0 || txQ.size() != 0 || txBusy) && drainCnt < DrainTimeout) begin
      @(negedge clk_29_pll);
      drainCnt++;
    end
    assert (drainCnt < DrainTimeout)
      else begin
        otherErrs++;
        $display("timeout waiting for echo, %0d rx and %0d tx bytes left",
                 rxQ.size(), txQ.size());
      end
    assert (frameErrSeen == frameErrExp)
      else begin
        mismatchErrs++;
        $display("Mismatch rxFrameError pulses: got %h expected %h", frameErrSeen, frameErrExp);
      end
    $display("error counts: %0d mismatch, %0d other", mismatchErrs, otherErrs);
    if (mismatchErrs == 0 && otherErrs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // hard limit on the whole run
  initial begin
    repeat (WatchdogClocks) @(posedge clk_29_pll);
    $display("watchdog expired before the run finished");
    $display("error counts: %0d mismatch, %0d other", mismatchErrs, otherErrs + 1);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* echoInput.txt */
// columns kind_byte_stop_gap, all hex
// kind 0 frame, 1 glitch (20 clock low pulse), f end; stop 1 good, 0 low; gap in bit times
0_a5_1_3  // single byte
0_3c_1_0  // back to back run
0_81_1_0
0_7e_1_0
0_00_1_4
0_c3_0_2  // low stop bit, never echoed
0_5a_1_2
0_ff_1_1
1_00_0_3  // glitch on rxd
0_96_1_0
0_69_1_2
f_00_0_0  // end of stimulus

/* uartEcho.f */
uartPkg.sv
uartBaudTick.sv
uartReceiver.sv
echoFifo.sv
uartTransmitter.sv
uartEcho.sv
tbUartEcho.sv

/* Bender.yml */
package:
  name: uartEcho

sources:
  - files:
      - uartPkg.sv
      - uartBaudTick.sv
      - uartReceiver.sv
      - echoFifo.sv
      - uartTransmitter.sv
      - uartEcho.sv
  - target: test
    files:
      - tbUartEcho.sv
